// File: hdl/logger_ctrl_if.sv
interface logger_ctrl_if;

    // strobes from the controller.
    logic store_hdr;
    logic store_len;
    logic incr_body;
    logic mod_hdr;
    logic log_wr;

    // status back from the datapath.
    logic last_flit;
    logic log_full;

    modport ctrl (
        output store_hdr, store_len, incr_body, mod_hdr, log_wr,
        input  last_flit, log_full
    );

    modport datap (
        input  store_hdr, store_len, incr_body, mod_hdr, log_wr,
        output last_flit, log_full
    );

endinterface

// File: hdl/tcp_logger_axil_reader.sv
module tcp_logger_axil_reader (
     input  logic clk
    ,input  logic rst

    ,input  logic                                   arvalid
    ,output logic                                   arready
    ,input  logic [tcp_logger_pkg::AXIL_ADDR_W-1:0] araddr
    ,output logic                                   rvalid
    ,input  logic                                   rready
    ,output logic [tcp_logger_pkg::AXIL_DATA_W-1:0] rdata
    ,output logic [1:0]                             rresp

    ,input  logic                                   awvalid
    ,output logic                                   awready
    ,input  logic                                   wvalid
    ,output logic                                   wready
    ,output logic                                   bvalid
    ,input  logic                                   bready
    ,output logic [1:0]                             bresp

    ,input  logic [tcp_logger_pkg::LOG_ADDR_W:0]    entry_count
    ,output logic [tcp_logger_pkg::LOG_ADDR_W-1:0]  rd_addr
    ,input  tcp_logger_pkg::log_entry_t             rd_entry
);
    localparam int REGION_LSB = tcp_logger_pkg::LOG_ENTRY_SHIFT + tcp_logger_pkg::LOG_ADDR_W;
    localparam int AW = tcp_logger_pkg::AXIL_ADDR_W;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_RESP
    } rd_state_t;

    rd_state_t rd_state;
    logic is_count;
    logic is_log;
    logic is_count_q;
    logic is_log_q;
    logic [tcp_logger_pkg::LOG_WORD_IDX_W-1:0] word_idx;
    logic [tcp_logger_pkg::LOG_WORD_IDX_W-1:0] word_q;
    logic [tcp_logger_pkg::AXIL_DATA_W-1:0] entry_word;
    logic wr_acc;

    // ####################################################################
    // read path
    // ####################################################################
    assign word_idx = araddr[2 +: tcp_logger_pkg::LOG_WORD_IDX_W];
    assign is_count = araddr[AW-1:2] == tcp_logger_pkg::REG_COUNT_ADDR[AW-1:2];
    assign is_log = (araddr[AW-1:REGION_LSB] == tcp_logger_pkg::LOG_BASE_ADDR[AW-1:REGION_LSB])
        && (word_idx < tcp_logger_pkg::LOG_WORD_IDX_W'(tcp_logger_pkg::LOG_WORDS));

    assign rd_addr = araddr[tcp_logger_pkg::LOG_ENTRY_SHIFT +: tcp_logger_pkg::LOG_ADDR_W];
    assign arready = rd_state == RD_IDLE;
    assign rvalid = rd_state == RD_RESP;

    always_comb begin
        case (word_q)
            3'd0: entry_word = rd_entry.timestamp;
            3'd1: entry_word = 32'(rd_entry.pkt_len);
            3'd2: entry_word = rd_entry.log_pkt_hdr[159:128]; // msw first.
            3'd3: entry_word = rd_entry.log_pkt_hdr[127:96];
            3'd4: entry_word = rd_entry.log_pkt_hdr[95:64];
            3'd5: entry_word = rd_entry.log_pkt_hdr[63:32];
            default: entry_word = rd_entry.log_pkt_hdr[31:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (arvalid) rd_state <= RD_MEM;
                RD_MEM: rd_state <= RD_RESP;
                default: if (rready) rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            is_count_q <= is_count;
            is_log_q <= is_log;
            word_q <= word_idx;
        end
        if (rd_state == RD_MEM) begin
            if (is_log_q) begin
                rdata <= entry_word;
                rresp <= tcp_logger_pkg::AXI_RESP_OKAY;
            end else if (is_count_q) begin
                rdata <= 32'(entry_count);
                rresp <= tcp_logger_pkg::AXI_RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= tcp_logger_pkg::AXI_RESP_SLVERR;
            end
        end
    end

    // ####################################################################
    // write path, always rejected
    // ####################################################################
    assign awready = wr_acc;
    assign wready = wr_acc;
    assign bresp = tcp_logger_pkg::AXI_RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_acc <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wr_acc <= awvalid & wvalid & ~wr_acc & ~bvalid; // one cycle pulse.
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/tcp_logger_log_mem.sv
module tcp_logger_log_mem (
     input  logic clk

    ,input  logic                                  wr_en
    ,input  logic [tcp_logger_pkg::LOG_ADDR_W-1:0] wr_addr
    ,input  tcp_logger_pkg::log_entry_t            wr_entry

    ,input  logic [tcp_logger_pkg::LOG_ADDR_W-1:0] rd_addr
    ,output tcp_logger_pkg::log_entry_t            rd_entry
);
    localparam int DEPTH = 1 << tcp_logger_pkg::LOG_ADDR_W;

    tcp_logger_pkg::log_entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_addr];
    end

endmodule

// File: hdl/tcp_logger_pkg.sv
package tcp_logger_pkg;

    // ####################################################################
    // widths
    // ####################################################################
    localparam int NOC_DATA_W = 256;
    localparam int MSG_LEN_W = 8;
    localparam int TOT_LEN_W = 16;
    localparam int TCP_HDR_W = 160;
    localparam int TIMESTAMP_W = 32;

    localparam int LOG_ENTRIES_LOG_2 = 4; // 16 entries.
    localparam int LOG_ADDR_W = LOG_ENTRIES_LOG_2;

    localparam logic [7:0] FORWARD_X = 8'h03;
    localparam logic [7:0] FORWARD_Y = 8'h05;

    // ####################################################################
    // flit and log formats
    // ####################################################################
    typedef struct packed {
        logic [7:0] dst_x;
        logic [7:0] dst_y;
        logic [7:0] src_x;
        logic [7:0] src_y;
        logic [MSG_LEN_W-1:0] msg_len; // body flits.
        logic [7:0] msg_type;
        logic [NOC_DATA_W-48-1:0] padding;
    } noc_hdr_flit;

    typedef struct packed {
        logic [TOT_LEN_W-1:0] data_payload_len;
        logic [NOC_DATA_W-TOT_LEN_W-1:0] padding;
    } ip_rx_meta_flit;

    typedef logic [TCP_HDR_W-1:0] tcp_pkt_hdr;

    typedef struct packed {
        logic [TIMESTAMP_W-1:0] timestamp;
        logic [TOT_LEN_W-1:0] pkt_len;
        tcp_pkt_hdr log_pkt_hdr;
    } log_entry_t;

    // ####################################################################
    // host register map
    // ####################################################################
    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_DATA_W = 32;
    localparam int LOG_WORDS = 7;
    localparam int LOG_WORD_IDX_W = 3;
    localparam int LOG_ENTRY_SHIFT = 5; // 32 bytes per entry.

    localparam logic [AXIL_ADDR_W-1:0] REG_COUNT_ADDR = 12'h000;
    localparam logic [AXIL_ADDR_W-1:0] LOG_BASE_ADDR = 12'h400;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

// File: hdl/tcp_logger_record_ctrl.sv
module tcp_logger_record_ctrl (
     input  logic clk
    ,input  logic rst

    ,input  logic in_val
    ,output logic in_rdy
    ,input  logic out_rdy

    ,logger_ctrl_if.ctrl ctrl
);
    typedef enum logic [1:0] {
        ST_HDR,
        ST_META,
        ST_TCP,
        ST_BODY
    } state_t;

    state_t state_reg;
    state_t state_next;
    logic flit_hs;

    // link is a straight pass-through, ready comes from downstream.
    assign in_rdy = out_rdy;
    assign flit_hs = in_val & out_rdy;

    always_comb begin
        state_next = state_reg;
        ctrl.store_hdr = 1'b0;
        ctrl.store_len = 1'b0;
        ctrl.incr_body = 1'b0;
        ctrl.mod_hdr = 1'b0;
        ctrl.log_wr = 1'b0;

        case (state_reg)
            ST_HDR: begin
                ctrl.mod_hdr = 1'b1; // rewrite destination.
                ctrl.store_hdr = flit_hs;
                if (flit_hs) begin
                    state_next = ST_META;
                end
            end
            ST_META: begin
                ctrl.store_len = flit_hs;
                ctrl.incr_body = flit_hs;
                if (flit_hs) begin
                    state_next = ctrl.last_flit ? ST_HDR : ST_TCP;
                end
            end
            ST_TCP: begin
                ctrl.incr_body = flit_hs;
                ctrl.log_wr = flit_hs & ~ctrl.log_full; // drop once full.
                if (flit_hs) begin
                    state_next = ctrl.last_flit ? ST_HDR : ST_BODY;
                end
            end
            default: begin
                ctrl.incr_body = flit_hs;
                if (flit_hs && ctrl.last_flit) begin
                    state_next = ST_HDR;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_HDR;
        end else begin
            state_reg <= state_next;
        end
    end

endmodule

// File: hdl/tcp_logger_record_datap.sv
module tcp_logger_record_datap (
     input  logic clk
    ,input  logic rst

    ,input  logic [tcp_logger_pkg::NOC_DATA_W-1:0] in_data
    ,output logic [tcp_logger_pkg::NOC_DATA_W-1:0] out_data

    ,logger_ctrl_if.datap datap

    ,output logic                                  wr_en
    ,output logic [tcp_logger_pkg::LOG_ADDR_W-1:0] wr_addr
    ,output tcp_logger_pkg::log_entry_t            wr_entry

    ,output logic [tcp_logger_pkg::LOG_ADDR_W:0]   entry_count
);
    tcp_logger_pkg::noc_hdr_flit hdr_in;
    tcp_logger_pkg::noc_hdr_flit hdr_out;
    tcp_logger_pkg::ip_rx_meta_flit meta_in;

    logic [tcp_logger_pkg::MSG_LEN_W-1:0] msg_len_reg;
    logic [tcp_logger_pkg::MSG_LEN_W-1:0] body_cnt_reg;
    logic [tcp_logger_pkg::TOT_LEN_W-1:0] pkt_len_reg;
    logic [tcp_logger_pkg::TIMESTAMP_W-1:0] timestamp_reg;
    logic [tcp_logger_pkg::LOG_ADDR_W:0] log_addr_reg; // msb is the full bit.

    assign hdr_in = in_data;
    assign meta_in = in_data;

    // ####################################################################
    // forwarding
    // ####################################################################
    always_comb begin
        hdr_out = hdr_in;
        if (datap.mod_hdr) begin
            hdr_out.dst_x = tcp_logger_pkg::FORWARD_X;
            hdr_out.dst_y = tcp_logger_pkg::FORWARD_Y;
        end
    end

    assign out_data = hdr_out;

    // ####################################################################
    // message tracking and logging
    // ####################################################################
    assign datap.last_flit = body_cnt_reg == (msg_len_reg - 1'b1);
    assign datap.log_full = log_addr_reg[tcp_logger_pkg::LOG_ADDR_W];

    assign wr_en = datap.log_wr;
    assign wr_addr = log_addr_reg[tcp_logger_pkg::LOG_ADDR_W-1:0];
    assign entry_count = log_addr_reg;

    assign wr_entry.timestamp = timestamp_reg;
    assign wr_entry.pkt_len = pkt_len_reg;
    assign wr_entry.log_pkt_hdr =
        in_data[tcp_logger_pkg::NOC_DATA_W-1 -: tcp_logger_pkg::TCP_HDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            timestamp_reg <= '0;
            log_addr_reg <= '0;
            body_cnt_reg <= '0;
        end else begin
            timestamp_reg <= timestamp_reg + 1'b1;
            if (datap.log_wr) begin
                log_addr_reg <= log_addr_reg + 1'b1;
            end
            if (datap.store_hdr) begin
                body_cnt_reg <= '0;
            end else if (datap.incr_body) begin
                body_cnt_reg <= body_cnt_reg + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (datap.store_hdr) begin
            msg_len_reg <= hdr_in.msg_len;
        end
        if (datap.store_len) begin
            pkt_len_reg <= meta_in.data_payload_len;
        end
    end

endmodule

// File: hdl/tcp_logger_top.sv
module tcp_logger_top (
     input  logic clk
    ,input  logic rst

    ,input  logic                                   in_val
    ,input  logic [tcp_logger_pkg::NOC_DATA_W-1:0]  in_data
    ,output logic                                   in_rdy

    ,output logic                                   out_val
    ,output logic [tcp_logger_pkg::NOC_DATA_W-1:0]  out_data
    ,input  logic                                   out_rdy

    ,input  logic                                   arvalid
    ,output logic                                   arready
    ,input  logic [tcp_logger_pkg::AXIL_ADDR_W-1:0] araddr
    ,output logic                                   rvalid
    ,input  logic                                   rready
    ,output logic [tcp_logger_pkg::AXIL_DATA_W-1:0] rdata
    ,output logic [1:0]                             rresp
    ,input  logic                                   awvalid
    ,output logic                                   awready
    ,input  logic                                   wvalid
    ,output logic                                   wready
    ,output logic                                   bvalid
    ,input  logic                                   bready
    ,output logic [1:0]                             bresp
);
    logger_ctrl_if ctrl_if ();

    logic wr_en;
    logic [tcp_logger_pkg::LOG_ADDR_W-1:0] wr_addr;
    logic [tcp_logger_pkg::LOG_ADDR_W-1:0] rd_addr;
    logic [tcp_logger_pkg::LOG_ADDR_W:0] entry_count;
    tcp_logger_pkg::log_entry_t wr_entry;
    tcp_logger_pkg::log_entry_t rd_entry;

    assign out_val = in_val; // no storage on the link.

    tcp_logger_record_ctrl u_ctrl (
         .clk     (clk)
        ,.rst     (rst)
        ,.in_val  (in_val)
        ,.in_rdy  (in_rdy)
        ,.out_rdy (out_rdy)
        ,.ctrl    (ctrl_if.ctrl)
    );

    tcp_logger_record_datap u_datap (
         .clk         (clk)
        ,.rst         (rst)
        ,.in_data     (in_data)
        ,.out_data    (out_data)
        ,.datap       (ctrl_if.datap)
        ,.wr_en       (wr_en)
        ,.wr_addr     (wr_addr)
        ,.wr_entry    (wr_entry)
        ,.entry_count (entry_count)
    );

    tcp_logger_log_mem u_mem (
         .clk      (clk)
        ,.wr_en    (wr_en)
        ,.wr_addr  (wr_addr)
        ,.wr_entry (wr_entry)
        ,.rd_addr  (rd_addr)
        ,.rd_entry (rd_entry)
    );

    tcp_logger_axil_reader u_reader (
         .clk         (clk)
        ,.rst         (rst)
        ,.arvalid     (arvalid)
        ,.arready     (arready)
        ,.araddr      (araddr)
        ,.rvalid      (rvalid)
        ,.rready      (rready)
        ,.rdata       (rdata)
        ,.rresp       (rresp)
        ,.awvalid     (awvalid)
        ,.awready     (awready)
        ,.wvalid      (wvalid)
        ,.wready      (wready)
        ,.bvalid      (bvalid)
        ,.bready      (bready)
        ,.bresp       (bresp)
        ,.entry_count (entry_count)
        ,.rd_addr     (rd_addr)
        ,.rd_entry    (rd_entry)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tcp_logger_tb \
    -f sources.f -o tcp_logger_sim

# keep running past assertion failures so the testbench can report them.
./obj_dir/tcp_logger_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi

// File: sim/tcp_logger_checker.sv
module tcp_logger_checker (
     input  logic clk
    ,input  logic rst

    ,input  logic                                   in_val
    ,input  logic [tcp_logger_pkg::NOC_DATA_W-1:0]  in_data
    ,input  logic                                   in_rdy
    ,input  logic                                   out_val
    ,input  logic [tcp_logger_pkg::NOC_DATA_W-1:0]  out_data
    ,input  logic                                   out_rdy

    ,input  logic                                   arvalid
    ,input  logic                                   arready
    ,input  logic [tcp_logger_pkg::AXIL_ADDR_W-1:0] araddr
    ,input  logic                                   rvalid
    ,input  logic                                   rready
    ,input  logic [tcp_logger_pkg::AXIL_DATA_W-1:0] rdata
    ,input  logic [1:0]                             rresp
    ,input  logic                                   awvalid
    ,input  logic                                   awready
    ,input  logic                                   wvalid
    ,input  logic                                   wready
    ,input  logic                                   bvalid
    ,input  logic                                   bready
    ,input  logic [1:0]                             bresp

    ,input  int                                     exp_flits
    ,input  logic                                   end_check
    ,output int                                     link_errors
    ,output int                                     host_errors
);
    localparam int N_ENTRIES = 1 << tcp_logger_pkg::LOG_ADDR_W;

    tcp_logger_pkg::log_entry_t model [N_ENTRIES];
    tcp_logger_pkg::noc_hdr_flit exp_flit;
    int log_count;
    int flit_count;
    int flit_pos;
    int rd_lat;
    int aw_count;
    int w_count;
    int b_count;
    logic [7:0] cur_len;
    logic [15:0] cur_pkt_len;
    logic [31:0] ts;
    logic [31:0] exp_rdata;
    logic [1:0] exp_rresp;
    logic rd_pend;
    logic rv_seen;
    logic end_done;

    function logic [31:0] entry_word(input tcp_logger_pkg::log_entry_t e, input int w);
        case (w)
            0: return e.timestamp;
            1: return {16'h0000, e.pkt_len};
            default: return e.log_pkt_hdr[159 - 32 * (w - 2) -: 32]; // msw first.
        endcase
    endfunction

    task predict_read(input logic [11:0] addr);
        int off;
        off = int'(addr) - int'(tcp_logger_pkg::LOG_BASE_ADDR);
        exp_rdata = '0;
        exp_rresp = tcp_logger_pkg::AXI_RESP_SLVERR;
        if (addr == tcp_logger_pkg::REG_COUNT_ADDR) begin
            exp_rdata = log_count;
            exp_rresp = tcp_logger_pkg::AXI_RESP_OKAY;
        end else if (off >= 0 && off < 32 * N_ENTRIES
                && (off % 32) / 4 < tcp_logger_pkg::LOG_WORDS) begin
            exp_rdata = entry_word(model[off / 32], (off % 32) / 4);
            exp_rresp = tcp_logger_pkg::AXI_RESP_OKAY;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ts = '0;
            flit_pos = 0;
            flit_count = 0;
            log_count = 0;
            aw_count = 0;
            w_count = 0;
            b_count = 0;
            rd_pend = 1'b0;
            end_done = 1'b0;
        end else begin
            // ################################################################
            // link
            // ################################################################
            if (in_rdy !== out_rdy) begin
                $display("Error: in_rdy exp %h got %h", out_rdy, in_rdy);
                link_errors++;
            end
            if (out_val !== in_val) begin
                $display("Error: out_val exp %h got %h", in_val, out_val);
                link_errors++;
            end
            if (in_val && out_rdy) begin
                exp_flit = in_data;
                if (flit_pos == 0) begin
                    exp_flit.dst_x = tcp_logger_pkg::FORWARD_X;
                    exp_flit.dst_y = tcp_logger_pkg::FORWARD_Y;
                    cur_len = exp_flit.msg_len;
                end else if (flit_pos == 1) begin
                    cur_pkt_len = in_data[255 -: 16];
                end else if (flit_pos == 2 && log_count < N_ENTRIES) begin
                    model[log_count] = {ts, cur_pkt_len, in_data[255 -: 160]};
                    log_count++;
                end
                if (out_data !== exp_flit) begin
                    $display("Error: out_data exp %h got %h", exp_flit, out_data);
                    link_errors++;
                end
                flit_pos = (flit_pos == int'(cur_len)) ? 0 : flit_pos + 1;
                flit_count++;
            end

            // ################################################################
            // host port
            // ################################################################
            if (arready !== !rd_pend) begin
                $display("Error: arready exp %h got %h", !rd_pend, arready);
                host_errors++;
            end
            if (rvalid && !rd_pend) begin
                $display("Read data was offered with no read in progress");
                host_errors++;
            end
            if (rd_pend) begin
                rd_lat++;
                if (rvalid && !rv_seen) begin
                    rv_seen = 1'b1;
                    if (rd_lat != 2) begin
                        $display("Read data came %0d cycles after the address, not 2", rd_lat);
                        host_errors++;
                    end
                end
                if (rvalid && rready) begin
                    rd_pend = 1'b0;
                    if (rdata !== exp_rdata || rresp !== exp_rresp) begin
                        $display("Error: rdata/rresp at %h exp %h/%h got %h/%h",
                            araddr, exp_rdata, exp_rresp, rdata, rresp);
                        host_errors++;
                    end
                end
            end
            if (arvalid && arready) begin
                predict_read(araddr);
                rd_pend = 1'b1;
                rv_seen = 1'b0;
                rd_lat = 0;
            end

            // a response needs both the address and the data of a write.
            if (bvalid && (aw_count == b_count || w_count == b_count)) begin
                $display("Write response came before the write was accepted");
                host_errors++;
            end
            if (bvalid && bready) begin
                b_count++;
                if (bresp !== tcp_logger_pkg::AXI_RESP_SLVERR) begin
                    $display("Error: bresp exp %h got %h",
                        tcp_logger_pkg::AXI_RESP_SLVERR, bresp);
                    host_errors++;
                end
            end
            if (awvalid && awready) begin
                aw_count++;
            end
            if (wvalid && wready) begin
                w_count++;
            end

            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (flit_count != exp_flits || flit_pos != 0) begin
                    $display("Link moved %0d flits, %0d were sent", flit_count, exp_flits);
                    link_errors++;
                end
                if (aw_count != b_count || w_count != b_count) begin
                    $display("Writes took %0d addresses and %0d data beats for %0d responses",
                        aw_count, w_count, b_count);
                    host_errors++;
                end
            end
            ts = ts + 1'b1;
        end
    end

endmodule

// File: sim/tcp_logger_sva.sv
module tcp_logger_sva (
     input  logic clk
    ,input  logic rst
    ,input  logic in_val
    ,input  logic in_rdy
    ,input  logic out_rdy
    ,input  logic [tcp_logger_pkg::NOC_DATA_W-1:0] in_data
    ,input  logic mod_hdr
    ,input  logic log_wr
    ,input  logic log_full
);
    tcp_logger_pkg::noc_hdr_flit hdr;
    int fail_count;

    assign hdr = in_data;

    rdy_follows_out: assert property (@(posedge clk) disable iff (rst) in_rdy == out_rdy)
        else begin
            $error("in_rdy does not follow out_rdy");
            fail_count = fail_count + 1;
        end

    no_write_when_full: assert property (@(posedge clk) disable iff (rst) !(log_wr && log_full))
        else begin
            $error("log write while the log is full");
            fail_count = fail_count + 1;
        end

    // mod_hdr marks the header state.
    min_body_flits: assert property (@(posedge clk) disable iff (rst)
        (in_val && in_rdy && mod_hdr) |-> (hdr.msg_len >= 8'd2))
        else begin
            $error("header with fewer than two body flits");
            fail_count = fail_count + 1;
        end

endmodule

bind tcp_logger_top tcp_logger_sva u_sva (
     .clk      (clk)
    ,.rst      (rst)
    ,.in_val   (in_val)
    ,.in_rdy   (in_rdy)
    ,.out_rdy  (out_rdy)
    ,.in_data  (in_data)
    ,.mod_hdr  (ctrl_if.mod_hdr)
    ,.log_wr   (ctrl_if.log_wr)
    ,.log_full (ctrl_if.log_full)
);

// File: sim/tcp_logger_tb.sv
module tcp_logger_tb;

    localparam int N_MSG = 18;
    localparam int N_ENTRIES = 1 << tcp_logger_pkg::LOG_ADDR_W;
    // count after each message, every entry twice, closing count, two unmapped reads, one write.
    localparam int N_READS = N_MSG + 2 * N_ENTRIES * tcp_logger_pkg::LOG_WORDS + 4;

    typedef struct packed {
        logic [7:0] msg_len;
        logic [15:0] pay_len;
        logic [31:0] hdr_seed;
        logic [7:0] stall; // out_rdy per cycle, lsb first.
    } msg_row_t;

    msg_row_t msg_table [N_MSG] = '{
        '{8'd2, 16'd40, 32'h0000_1001, 8'hff},
        '{8'd3, 16'd512, 32'h1a2b_3c4d, 8'b1010_1011},
        '{8'd4, 16'd1460, 32'hdead_0001, 8'b1100_1101},
        '{8'd2, 16'd0, 32'h0bad_f00d, 8'b0000_0001},
        '{8'd5, 16'd9000, 32'h5555_aaaa, 8'hff},
        '{8'd3, 16'd64, 32'h7f00_0001, 8'b1110_0111},
        '{8'd2, 16'd1, 32'hc0a8_0101, 8'b1001_1001},
        '{8'd6, 16'd1500, 32'h1234_5678, 8'hff},
        '{8'd2, 16'hffff, 32'hffff_0000, 8'b0101_0101},
        '{8'd3, 16'd333, 32'h0f0f_0f0f, 8'hff},
        '{8'd4, 16'd777, 32'h8000_0000, 8'b1111_0001},
        '{8'd2, 16'd20, 32'h0000_0002, 8'hff},
        '{8'd3, 16'd4096, 32'h3c3c_c3c3, 8'b1011_1111},
        '{8'd2, 16'd1024, 32'h9abc_def0, 8'hff},
        '{8'd5, 16'd88, 32'h2468_ace0, 8'b1101_0110},
        '{8'd2, 16'd256, 32'h1357_9bdf, 8'hff},
        '{8'd3, 16'd600, 32'hfeed_beef, 8'b0011_0011}, // log is full from here on.
        '{8'd4, 16'd700, 32'hcafe_0018, 8'hff}
    };

    logic clk;
    logic rst;
    logic in_val;
    logic [tcp_logger_pkg::NOC_DATA_W-1:0] in_data;
    logic in_rdy;
    logic out_val;
    logic [tcp_logger_pkg::NOC_DATA_W-1:0] out_data;
    logic out_rdy;
    logic arvalid;
    logic arready;
    logic [tcp_logger_pkg::AXIL_ADDR_W-1:0] araddr;
    logic rvalid;
    logic rready;
    logic [tcp_logger_pkg::AXIL_DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;

    logic [31:0] lcg_state = 32'h186f;
    logic [2:0] stall_idx;
    logic end_check;
    int exp_flits;
    int link_errors;
    int host_errors;
    int cycle_count;
    int timeout_limit;

    tcp_logger_top uut (.*);

    tcp_logger_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function logic [255:0] random_flit();
        logic [255:0] f;
        for (int i = 0; i < 8; i++) begin
            f[32 * i +: 32] = next_random();
        end
        return f;
    endfunction

    function logic [159:0] tcp_header(input logic [31:0] seed);
        return {seed, seed * 32'd3, seed * 32'd5, seed * 32'd7, ~seed};
    endfunction

    function int total_flits();
        int n;
        n = 0;
        for (int m = 0; m < N_MSG; m++) begin
            n += int'(msg_table[m].msg_len) + 1;
        end
        return n;
    endfunction

    // tasks start and end on a falling edge.
    task send_flit(input logic [255:0] flit, input logic [7:0] stall);
        in_val = 1'b1;
        in_data = flit;
        out_rdy = stall[stall_idx];
        stall_idx = stall_idx + 1'b1;
        @(negedge clk);
        while (!in_rdy) begin
            out_rdy = stall[stall_idx];
            stall_idx = stall_idx + 1'b1;
            @(negedge clk);
        end
    endtask

    task send_message(input msg_row_t row);
        tcp_logger_pkg::noc_hdr_flit hdr;
        tcp_logger_pkg::ip_rx_meta_flit meta;
        logic [255:0] flit;
        stall_idx = '0;
        hdr = random_flit();
        hdr.msg_len = row.msg_len;
        send_flit(hdr, row.stall);
        meta = random_flit();
        meta.data_payload_len = row.pay_len;
        send_flit(meta, row.stall);
        flit = random_flit();
        flit[255 -: 160] = tcp_header(row.hdr_seed);
        send_flit(flit, row.stall);
        for (int b = 2; b < int'(row.msg_len); b++) begin
            send_flit(random_flit(), row.stall);
        end
        in_val = 1'b0;
        out_rdy = 1'b1;
    endtask

    task axi_read(input logic [11:0] addr);
        arvalid = 1'b1;
        araddr = addr;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task read_entry(input int idx);
        for (int w = 0; w < tcp_logger_pkg::LOG_WORDS; w++) begin
            axi_read(12'(tcp_logger_pkg::LOG_BASE_ADDR + 32 * idx + 4 * w));
        end
    endtask

    task axi_write();
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int total_errors;
        rst = 1'b1;
        in_val = 1'b0;
        in_data = '0;
        out_rdy = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        end_check = 1'b0;
        stall_idx = '0;
        exp_flits = total_flits();
        timeout_limit = 20 * exp_flits + 10 * N_READS;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int m = 0; m < N_MSG; m++) begin
            send_message(msg_table[m]);
            axi_read(tcp_logger_pkg::REG_COUNT_ADDR);
            if (m < N_ENTRIES) begin
                read_entry(m);
            end
        end

        // full log, then the older entries once more.
        axi_read(tcp_logger_pkg::REG_COUNT_ADDR);
        for (int e = 0; e < N_ENTRIES; e++) begin
            read_entry(e);
        end
        axi_read(12'h41c); // word 7 does not exist.
        axi_read(12'h800);
        axi_write();

        end_check = 1'b1;
        @(negedge clk);
        @(negedge clk);
        total_errors = link_errors + host_errors + uut.u_sva.fail_count;
        $display("errors: link %0d, host %0d, assertions %0d",
            link_errors, host_errors, uut.u_sva.fail_count);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/tcp_logger_pkg.sv
hdl/logger_ctrl_if.sv
hdl/tcp_logger_record_ctrl.sv
hdl/tcp_logger_record_datap.sv
hdl/tcp_logger_log_mem.sv
hdl/tcp_logger_axil_reader.sv
hdl/tcp_logger_top.sv
sim/tcp_logger_sva.sv
sim/tcp_logger_checker.sv
sim/tcp_logger_tb.sv
